// File: src/exec_pkg.sv
// Shared definitions for the execute stage
// The op field of an instruction carries one of the four sub-operation
// enumerations in its low bits; the decoder picks which one
// Write-back index 0..31 addresses GPRs, 32..63 addresses CSRs
package exec_pkg;

	// Operation class from the decoder
	typedef enum logic [2:0] {
		OP_ARITH,
		OP_BRANCH,
		OP_LDST,
		OP_MDS,
		OP_JUMP,
		OP_SYSTEM,
		OP_CSR
	} op_type_e;

	// ALU operations, compares answer in bit 0
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
		ALU_OPA, ALU_OPB
	} alu_op_e;

	// Load/store kinds, loads first
	typedef enum logic [3:0] {
		MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// Multi-cycle unit operations
	typedef enum logic [3:0] {
		MDS_SLL, MDS_SRL, MDS_SRA,
		MDS_MUL, MDS_MULH, MDS_MULHU,
		MDS_DIV, MDS_DIVU, MDS_REM, MDS_REMU
	} mds_op_e;

	typedef enum logic [1:0] {
		SYS_ECALL,
		SYS_EBREAK,
		SYS_ERET
	} sys_op_e;

	parameter int OP_W = 6;

	// CSR slots in the write-back index space
	parameter logic [5:0] CSR_MEPC   = 6'd33;
	parameter logic [5:0] CSR_MCAUSE = 6'd34;
	parameter logic [5:0] CSR_MTVAL  = 6'd35;

	// Exception causes
	parameter logic [3:0] CAUSE_FETCH_FAULT = 4'd1;
	parameter logic [3:0] CAUSE_BREAK       = 4'd3;
	parameter logic [3:0] CAUSE_ECALL       = 4'd11;

	// Third operand, offset or CSR index depending on class
	typedef union packed {
		logic [31:0] imm;
		struct packed {
			logic [25:0] pad;
			logic [5:0]  idx;
		} csr;
	} exec_opc_u;

	// One decoded instruction
	typedef struct packed {
		op_type_e         op_type;
		logic [OP_W-1:0]  op;
		logic [31:0]      op_a;
		logic [31:0]      op_b;
		exec_opc_u        op_c;
		logic [5:0]       rd;
		logic             compressed;
	} exec_instr_t;

	// Register or CSR write
	typedef struct packed {
		logic        en;
		logic [5:0]  addr;
		logic [31:0] data;
	} exec_wb_t;

endpackage

// File: src/exec_alu.sv
// Combinational ALU
// Compare operations return 0 or 1 in bit 0, upper bits zero
`timescale 1ns/100ps

module exec_alu (
	input  logic [31:0]        op_a,
	input  logic [31:0]        op_b,
	input  exec_pkg::alu_op_e  op,
	output logic [31:0]        result
);
	import exec_pkg::*;

	logic eq;
	logic lt_s;
	logic lt_u;

	// Shared comparators for slt and branch compares
	assign eq   = (op_a == op_b);
	assign lt_s = ($signed(op_a) < $signed(op_b));
	assign lt_u = (op_a < op_b);

	always_comb begin
		result = 32'b0;
		case (op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			// Set-less-than and branch less-than share a comparator
			ALU_SLT, ALU_LT:   result[0] = lt_s;
			ALU_SLTU, ALU_LTU: result[0] = lt_u;
			ALU_EQ:  result[0] = eq;
			ALU_NE:  result[0] = !eq;
			ALU_GE:  result[0] = !lt_s;
			ALU_GEU: result[0] = !lt_u;
			// Pass-through for link address and CSR old value
			ALU_OPA: result = op_a;
			ALU_OPB: result = op_b;
			default: result = 32'b0;
		endcase
	end

endmodule

// File: src/exec_mul_div_shift.sv
// Iterative shift, multiply and divide unit
// Shifts take one cycle per bit, multiply and divide 32 steps plus one
// in_valid must not arrive while busy; out_valid is a one-cycle pulse
// With ENABLE_MUL_DIV = 0 multiply and divide return 0 after one cycle
`timescale 1ns/100ps

module exec_mul_div_shift #(
	parameter int ENABLE_MUL_DIV = 1
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               in_valid,
	input  logic [31:0]        in_a,
	input  logic [31:0]        in_b,
	input  exec_pkg::mds_op_e  op,
	output logic [31:0]        out,
	output logic               out_valid
);
	import exec_pkg::*;

	logic        busy;
	logic [5:0]  count;
	logic [5:0]  start_count;
	mds_op_e     op_r;
	// hi is product high / remainder, lo is shift value / product low / quotient
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] opd;
	logic        neg_q;
	logic        neg_r;
	logic        in_shift;
	logic        r_shift;
	logic        a_neg;
	logic        b_neg;
	logic [32:0] mul_sum;
	logic [32:0] rem_sh;
	logic [33:0] trial;
	logic [63:0] prod_s;
	logic [31:0] result;

	assign in_shift = (op inside {MDS_SLL, MDS_SRL, MDS_SRA});
	assign r_shift  = (op_r inside {MDS_SLL, MDS_SRL, MDS_SRA});

	// Signed ops work on magnitudes, sign restored at the end
	assign a_neg = (op inside {MDS_MULH, MDS_DIV, MDS_REM}) && in_a[31];
	assign b_neg = (op inside {MDS_MULH, MDS_DIV, MDS_REM}) && in_b[31];

	always_comb begin
		if (in_shift)
			start_count = {1'b0, in_b[4:0]};
		else if (ENABLE_MUL_DIV == 0)
			start_count = 6'd0;
		else
			start_count = 6'd32;
	end

	// Shift-and-add step, multiplier bits leave from lo[0]
	assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, opd} : 33'b0);
	// Restoring division step
	assign rem_sh  = {hi, lo[31]};
	assign trial   = {1'b0, rem_sh} - {2'b0, opd};

	always_comb begin
		prod_s = neg_q ? -{hi, lo} : {hi, lo};
		case (op_r)
			MDS_MUL:           result = lo;
			MDS_MULH:          result = prod_s[63:32];
			MDS_MULHU:         result = hi;
			MDS_DIV, MDS_DIVU: result = neg_q ? -lo : lo;
			MDS_REM, MDS_REMU: result = neg_r ? -hi : hi;
			default:           result = lo;
		endcase
		if (ENABLE_MUL_DIV == 0 && !r_shift)
			result = 32'b0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			count     <= 6'd0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (in_valid) begin
				busy  <= 1'b1;
				count <= start_count;
			end else if (busy) begin
				if (count == 6'd0) begin
					busy      <= 1'b0;
					out_valid <= 1'b1;
				end else begin
					count <= count - 6'd1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			op_r <= op;
			hi   <= 32'b0;
			lo   <= (!in_shift && a_neg) ? -in_a : in_a;
			opd  <= b_neg ? -in_b : in_b;
			// Divide by zero keeps an all-ones quotient
			neg_q <= (a_neg ^ b_neg) && (in_b != 32'b0);
			neg_r <= a_neg;
		end else if (busy && count != 6'd0) begin
			case (op_r)
				MDS_SLL: lo <= {lo[30:0], 1'b0};
				MDS_SRL: lo <= {1'b0, lo[31:1]};
				MDS_SRA: lo <= {lo[31], lo[31:1]};
				MDS_MUL, MDS_MULH, MDS_MULHU: begin
					hi <= mul_sum[32:1];
					lo <= {mul_sum[0], lo[31:1]};
				end
				default: begin
					hi <= trial[33] ? rem_sh[31:0] : trial[31:0];
					lo <= {lo[30:0], !trial[33]};
				end
			endcase
		end
		if (busy && count == 6'd0)
			out <= result;
	end

	// Sequencer must wait for out_valid before the next request
	assert property (@(posedge clock) disable iff (reset) in_valid |-> !busy);

endmodule

// File: src/exec_mem.sv
// Load/store unit on a valid/ready data bus
// Bus address is word aligned; misaligned accesses are not supported
// One request at a time, ack_valid pulses the cycle after the handshake
`timescale 1ns/100ps

module exec_mem (
	input  logic               clock,
	input  logic               reset,
	input  logic               req_valid,
	input  logic [31:0]        req_addr,
	input  exec_pkg::mem_op_e  req_op,
	input  logic [31:0]        req_data,
	output logic               ack_valid,
	output logic [31:0]        ack_data,
	output logic               dvalid,
	output logic [31:0]        daddr,
	output logic               dwrite,
	output logic [31:0]        dwdata,
	output logic [3:0]         dwstb,
	input  logic [31:0]        drdata,
	input  logic               dready
);
	import exec_pkg::*;

	mem_op_e     op_r;
	logic [1:0]  lane;
	logic [31:0] st_data;
	logic [3:0]  st_stb;
	logic [7:0]  rd_byte;
	logic [15:0] rd_half;
	logic [31:0] ld_data;

	// Store data replicated across the word, strobes pick the lanes
	always_comb begin
		case (req_op)
			MEM_SB: begin
				st_data = {4{req_data[7:0]}};
				st_stb  = 4'b0001 << req_addr[1:0];
			end
			MEM_SH: begin
				st_data = {2{req_data[15:0]}};
				st_stb  = req_addr[1] ? 4'b1100 : 4'b0011;
			end
			MEM_SW: begin
				st_data = req_data;
				st_stb  = 4'b1111;
			end
			// Loads drive no strobes
			default: begin
				st_data = req_data;
				st_stb  = 4'b0000;
			end
		endcase
	end

	// Load lane select and extension
	always_comb begin
		case (lane)
			2'd0:    rd_byte = drdata[7:0];
			2'd1:    rd_byte = drdata[15:8];
			2'd2:    rd_byte = drdata[23:16];
			default: rd_byte = drdata[31:24];
		endcase
		rd_half = lane[1] ? drdata[31:16] : drdata[15:0];
		case (op_r)
			MEM_LB:  ld_data = {{24{rd_byte[7]}}, rd_byte};
			MEM_LBU: ld_data = {24'b0, rd_byte};
			MEM_LH:  ld_data = {{16{rd_half[15]}}, rd_half};
			MEM_LHU: ld_data = {16'b0, rd_half};
			default: ld_data = drdata;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid    <= 1'b0;
			ack_valid <= 1'b0;
		end else begin
			ack_valid <= dvalid && dready;
			if (req_valid)
				dvalid <= 1'b1;
			else if (dready)
				dvalid <= 1'b0;
		end
	end

	// Request held for the whole bus transfer
	always_ff @(posedge clock) begin
		if (req_valid) begin
			daddr  <= {req_addr[31:2], 2'b00};
			dwrite <= (req_op inside {MEM_SB, MEM_SH, MEM_SW});
			dwdata <= st_data;
			dwstb  <= st_stb;
			op_r   <= req_op;
			lane   <= req_addr[1:0];
		end
		if (dvalid && dready)
			ack_data <= ld_data;
	end

	// Bus rule: no change under back-pressure
	assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata));

endmodule

// File: src/exec_unit.sv
// Execute sequencer: FSM, PC, operand select, write-back and exceptions
// decode_valid and instr must be held until instr_complete is seen
// wb is combinational and written at the next rising edge
// Data-execution window checked on jumps only, bits 31:3 inclusive
`timescale 1ns/100ps

module exec_unit #(
	parameter int          ENABLE_MUL_DIV = 1,
	parameter logic [31:0] RESET_PC       = 32'h8000_0000
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   decode_valid,
	input  exec_pkg::exec_instr_t  instr,
	output logic                   instr_complete,
	output exec_pkg::exec_wb_t     wb,
	output logic [31:0]            pc,
	output logic                   pc_seq,
	input  logic [31:0]            mtvec,
	input  logic [31:0]            dep_lo,
	input  logic [31:0]            dep_hi,
	output logic [31:0]            daddr,
	output logic                   dvalid,
	output logic                   dwrite,
	output logic [31:0]            dwdata,
	output logic [3:0]             dwstb,
	input  logic [31:0]            drdata,
	input  logic                   dready
);
	import exec_pkg::*;

	// One-hot states
	typedef enum logic [8:0] {
		ST_EXECUTE      = 9'b000000001,
		ST_BRANCH_TAKEN = 9'b000000010,
		ST_JUMP         = 9'b000000100,
		ST_CSR          = 9'b000001000,
		ST_MDS_WAIT     = 9'b000010000,
		ST_LDST_WAIT    = 9'b000100000,
		ST_EXC_EPC      = 9'b001000000,
		ST_EXC_TVAL     = 9'b010000000,
		ST_EXC_CAUSE    = 9'b100000000
	} state_e;

	state_e      state;
	logic [3:0]  mcause;
	logic        accept;
	logic [31:0] next_pc_seq;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	alu_op_e     alu_op;
	logic [31:0] alu_result;
	logic [31:0] target;
	logic        dep_violation;
	mem_op_e     mem_op;
	mds_op_e     mds_op;
	logic        mds_in_valid;
	logic        mds_out_valid;
	logic [31:0] mds_out;
	logic        mem_req_valid;
	logic        mem_ack_valid;
	logic [31:0] mem_ack_data;

	// Old instruction is still presented while instr_complete is high
	assign accept      = decode_valid && !instr_complete && (state == ST_EXECUTE);
	assign next_pc_seq = pc + (instr.compressed ? 32'd2 : 32'd4);
	assign mem_op      = mem_op_e'(instr.op[3:0]);
	assign mds_op      = mds_op_e'(instr.op[3:0]);

	// Jump target, bit 0 always cleared
	assign target = {alu_result[31:1], 1'b0};
	assign dep_violation = dep_lo[0] && dep_hi[0]
		&& !(target[31:3] >= dep_lo[31:3] && target[31:3] <= dep_hi[31:3]);

	// ALU operand and operation select
	always_comb begin
		alu_a  = instr.op_a;
		alu_b  = instr.op_b;
		alu_op = alu_op_e'(instr.op[3:0]);
		case (state)
			ST_EXECUTE: begin
				if (instr.op_type == OP_LDST) begin
					alu_b  = instr.op_c.imm;
					alu_op = ALU_ADD;
				end else if (instr.op_type == OP_JUMP) begin
					// Link address to rd
					alu_a  = next_pc_seq;
					alu_op = ALU_OPA;
				end
			end
			ST_BRANCH_TAKEN: begin
				alu_a  = pc;
				alu_b  = instr.op_c.imm;
				alu_op = ALU_ADD;
			end
			// CSR old value back to rd
			ST_CSR: alu_op = ALU_OPB;
			// Jump and exception states recompute op_a + imm
			default: begin
				alu_b  = instr.op_c.imm;
				alu_op = ALU_ADD;
			end
		endcase
	end

	// Write-back select
	always_comb begin
		wb.addr = instr.rd;
		wb.data = alu_result;
		wb.en   = 1'b0;
		case (state)
			ST_EXECUTE: begin
				wb.en = accept
					&& (instr.op_type inside {OP_ARITH, OP_JUMP, OP_CSR});
				// New CSR value goes to the CSR slot first
				if (instr.op_type == OP_CSR)
					wb.addr = instr.op_c.csr.idx;
			end
			ST_CSR: wb.en = 1'b1;
			ST_MDS_WAIT: begin
				wb.en   = mds_out_valid;
				wb.data = mds_out;
			end
			ST_LDST_WAIT: begin
				wb.en   = mem_ack_valid && (mem_op inside {MEM_LB, MEM_LH, MEM_LW,
					MEM_LBU, MEM_LHU});
				wb.data = mem_ack_data;
			end
			ST_EXC_EPC: begin
				wb.en   = 1'b1;
				wb.addr = CSR_MEPC;
				wb.data = pc;
			end
			ST_EXC_TVAL: begin
				wb.en   = 1'b1;
				wb.addr = CSR_MTVAL;
				wb.data = (mcause == CAUSE_FETCH_FAULT) ? target : 32'b0;
			end
			ST_EXC_CAUSE: begin
				wb.en   = 1'b1;
				wb.addr = CSR_MCAUSE;
				wb.data = {28'b0, mcause};
			end
			default: wb.en = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state          <= ST_EXECUTE;
			instr_complete <= 1'b0;
			pc             <= RESET_PC;
			pc_seq         <= 1'b1;
			mcause         <= 4'd0;
		end else begin
			instr_complete <= 1'b0;
			case (state)
				ST_EXECUTE: begin
					if (accept) begin
						case (instr.op_type)
							OP_LDST:   state <= ST_LDST_WAIT;
							OP_MDS:    state <= ST_MDS_WAIT;
							OP_JUMP:   state <= ST_JUMP;
							OP_CSR:    state <= ST_CSR;
							OP_SYSTEM: begin
								if (instr.op[1:0] == SYS_ERET) begin
									pc             <= instr.op_a;
									pc_seq         <= 1'b0;
									instr_complete <= 1'b1;
								end else begin
									mcause <= (instr.op[1:0] == SYS_EBREAK) ?
										CAUSE_BREAK : CAUSE_ECALL;
									state  <= ST_EXC_EPC;
								end
							end
							default: begin
								// Arith, or branch with compare in bit 0
								if (instr.op_type == OP_BRANCH && alu_result[0]) begin
									state <= ST_BRANCH_TAKEN;
								end else begin
									pc             <= next_pc_seq;
									pc_seq         <= 1'b1;
									instr_complete <= 1'b1;
								end
							end
						endcase
					end
				end
				ST_BRANCH_TAKEN: begin
					pc             <= alu_result;
					pc_seq         <= 1'b0;
					instr_complete <= 1'b1;
					state          <= ST_EXECUTE;
				end
				ST_JUMP: begin
					if (dep_violation) begin
						mcause <= CAUSE_FETCH_FAULT;
						state  <= ST_EXC_EPC;
					end else begin
						pc             <= target;
						pc_seq         <= 1'b0;
						instr_complete <= 1'b1;
						state          <= ST_EXECUTE;
					end
				end
				ST_CSR, ST_MDS_WAIT, ST_LDST_WAIT: begin
					// Sequential completion once the result is in
					if (state == ST_CSR || (state == ST_MDS_WAIT && mds_out_valid)
						|| (state == ST_LDST_WAIT && mem_ack_valid)) begin
						pc             <= next_pc_seq;
						pc_seq         <= 1'b1;
						instr_complete <= 1'b1;
						state          <= ST_EXECUTE;
					end
				end
				ST_EXC_EPC:  state <= ST_EXC_TVAL;
				ST_EXC_TVAL: state <= ST_EXC_CAUSE;
				default: begin
					// Cause written, now take the trap
					pc             <= mtvec;
					pc_seq         <= 1'b0;
					instr_complete <= 1'b1;
					state          <= ST_EXECUTE;
				end
			endcase
		end
	end

	assign mds_in_valid  = accept && (instr.op_type == OP_MDS);
	assign mem_req_valid = accept && (instr.op_type == OP_LDST);

	exec_alu u_alu (
		.op_a   (alu_a),
		.op_b   (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	exec_mul_div_shift #(
		.ENABLE_MUL_DIV (ENABLE_MUL_DIV)
	) u_mds (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (mds_in_valid),
		.in_a      (instr.op_a),
		.in_b      (instr.op_b),
		.op        (mds_op),
		.out       (mds_out),
		.out_valid (mds_out_valid)
	);

	exec_mem u_mem (
		.clock     (clock),
		.reset     (reset),
		.req_valid (mem_req_valid),
		.req_addr  (alu_result),
		.req_op    (mem_op),
		.req_data  (instr.op_b),
		.ack_valid (mem_ack_valid),
		.ack_data  (mem_ack_data),
		.dvalid    (dvalid),
		.daddr     (daddr),
		.dwrite    (dwrite),
		.dwdata    (dwdata),
		.dwstb     (dwstb),
		.drdata    (drdata),
		.dready    (dready)
	);

	// Unit results and the completion pulse never coincide
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({mem_ack_valid, mds_out_valid, instr_complete}));
	// Multi-write sequences move on every cycle
	assert property (@(posedge clock) disable iff (reset)
		wb.en |=> !wb.en || state != $past(state));

endmodule

// File: src/exec_top.sv
// Execute stage top level
// ENABLE_MUL_DIV = 0 leaves only shifts in the multi-cycle unit
// pc starts at RESET_PC with pc_seq high
`timescale 1ns/100ps

module exec_top #(
	parameter int          ENABLE_MUL_DIV = 1,
	parameter logic [31:0] RESET_PC       = 32'h8000_0000
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   decode_valid,
	input  exec_pkg::exec_instr_t  instr,
	output logic                   instr_complete,
	output exec_pkg::exec_wb_t     wb,
	output logic [31:0]            pc,
	output logic                   pc_seq,
	input  logic [31:0]            mtvec,
	input  logic [31:0]            dep_lo,
	input  logic [31:0]            dep_hi,
	output logic [31:0]            daddr,
	output logic                   dvalid,
	output logic                   dwrite,
	output logic [31:0]            dwdata,
	output logic [3:0]             dwstb,
	input  logic [31:0]            drdata,
	input  logic                   dready
);

	exec_unit #(
		.ENABLE_MUL_DIV (ENABLE_MUL_DIV),
		.RESET_PC       (RESET_PC)
	) u_exec (
		.*
	);

endmodule

// File: test/tb_exec.sv
// Testbench for exec_top with a reference model and a bus memory model
// Memory model covers 1 KiB, addresses wrap on bits 9:2
// Stops at the first mismatch or timeout
`timescale 1ns/100ps

module tb_exec;
	import exec_pkg::*;

	localparam logic [31:0] RESET_PC = 32'h0000_2000;
	localparam logic [31:0] MTVEC    = 32'h0000_0100;

	logic clock, reset, decode_valid, instr_complete, pc_seq;
	exec_instr_t instr;
	exec_wb_t wb;
	logic [31:0] pc, mtvec, dep_lo, dep_hi, daddr, dwdata, drdata;
	logic dvalid, dwrite, dready;
	logic [3:0] dwstb;

	logic [31:0] seed = 32'hfed5a10e;
	logic [31:0] mem [0:255];
	exec_wb_t exp_q [$];
	logic [31:0] exp_pc;
	logic exp_seq;
	int stall_left;
	bit bus_seen;
	logic [31:0] exp_daddr, exp_dwdata;
	logic exp_dwrite;
	logic [3:0] exp_dwstb;

	exec_top #(.ENABLE_MUL_DIV(1), .RESET_PC(RESET_PC)) uut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic abort();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			abort();
		end
	endtask

	task automatic expect_wb(input logic [5:0] addr, input logic [31:0] data);
		exp_q.push_back('{en: 1'b1, addr: addr, data: data});
	endtask

	// Reference ALU, compares answer in bit 0
	function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT, ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU, ALU_LTU: return {31'b0, a < b};
			ALU_EQ:  return {31'b0, a == b};
			ALU_NE:  return {31'b0, a != b};
			ALU_GE:  return {31'b0, $signed(a) >= $signed(b)};
			ALU_GEU: return {31'b0, a >= b};
			ALU_OPA: return a;
			ALU_OPB: return b;
			default: return 32'b0;
		endcase
	endfunction

	// Reference shifts, products and RISC-V style division
	function automatic logic [31:0] mds_ref(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] ps;
		logic [63:0] pu;
		logic signed [31:0] sq;
		logic signed [31:0] sr;
		logic ovf;
		ps  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		pu  = {32'b0, a} * {32'b0, b};
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		sq  = 32'sd0;
		sr  = 32'sd0;
		// Signed quotient and remainder truncate toward zero
		if (b != 0 && !ovf) begin
			sq = $signed(a) / $signed(b);
			sr = $signed(a) % $signed(b);
		end
		case (op)
			MDS_SLL:   return a << b[4:0];
			MDS_SRL:   return a >> b[4:0];
			MDS_SRA:   return $signed(a) >>> b[4:0];
			MDS_MUL:   return pu[31:0];
			MDS_MULH:  return ps[63:32];
			MDS_MULHU: return pu[63:32];
			MDS_DIV:   return (b == 0) ? 32'hffff_ffff : ovf ? a : sq;
			MDS_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
			MDS_REM:   return (b == 0) ? a : ovf ? 32'b0 : sr;
			MDS_REMU:  return (b == 0) ? a : a % b;
			default:   return 32'b0;
		endcase
	endfunction

	function automatic exec_instr_t rand_instr(input op_type_e t);
		exec_instr_t ins;
		ins.op_type    = t;
		ins.op         = 6'(next_rand() % 15);
		ins.op_a       = next_rand();
		ins.op_b       = next_rand();
		ins.op_c.imm   = next_rand();
		ins.rd         = {1'b0, 5'(next_rand())};
		ins.compressed = 1'(next_rand());
		return ins;
	endfunction

	function automatic logic [31:0] seq_pc(input logic compressed);
		return exp_pc + (compressed ? 32'd2 : 32'd4);
	endfunction

	// Present an instruction and hold it until instr_complete
	task automatic run_instr(input exec_instr_t ins);
		bit done;
		done = 0;
		instr        <= ins;
		decode_valid <= 1'b1;
		for (int n = 0; n < 300 && !done; n++) begin
			@(negedge clock);
			done = instr_complete;
		end
		if (!done) begin
			$display("timeout waiting for instr_complete");
			abort();
		end
	endtask

	task automatic do_arith();
		exec_instr_t ins;
		@(posedge clock);
		ins = rand_instr(OP_ARITH);
		expect_wb(ins.rd, alu_ref(ins.op[3:0], ins.op_a, ins.op_b));
		exp_pc  = seq_pc(ins.compressed);
		exp_seq = 1'b1;
		run_instr(ins);
	endtask

	task automatic do_branch();
		exec_instr_t ins;
		logic [31:0] cmp;
		@(posedge clock);
		ins    = rand_instr(OP_BRANCH);
		ins.op = 6'(6'd7 + next_rand() % 6);
		// Equal operands often enough to take eq branches
		if (next_rand() % 3 == 0)
			ins.op_b = ins.op_a;
		ins.op_c.imm[0] = 1'b0;
		cmp     = alu_ref(ins.op[3:0], ins.op_a, ins.op_b);
		exp_seq = !cmp[0];
		exp_pc  = exp_seq ? seq_pc(ins.compressed) : exp_pc + ins.op_c.imm;
		run_instr(ins);
	endtask

	task automatic do_jump();
		exec_instr_t ins;
		logic [31:0] tgt;
		@(posedge clock);
		ins          = rand_instr(OP_JUMP);
		ins.op_a     = 32'h0800_0000 + (next_rand() & 32'h1fff_ffff);
		ins.op_c.imm = next_rand() & 32'h0000_0fff;
		tgt = (ins.op_a + ins.op_c.imm) & ~32'd1;
		expect_wb(ins.rd, seq_pc(ins.compressed));
		exp_seq = 1'b0;
		if (dep_lo[0] && dep_hi[0]
			&& !(tgt[31:3] >= dep_lo[31:3] && tgt[31:3] <= dep_hi[31:3])) begin
			expect_wb(CSR_MEPC, exp_pc);
			expect_wb(CSR_MTVAL, tgt);
			expect_wb(CSR_MCAUSE, {28'b0, CAUSE_FETCH_FAULT});
			exp_pc = MTVEC;
		end else begin
			exp_pc = tgt;
		end
		run_instr(ins);
	endtask

	task automatic do_ldst();
		exec_instr_t ins;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] lval;
		logic [3:0] kind;
		@(posedge clock);
		ins  = rand_instr(OP_LDST);
		kind = 4'(next_rand() % 8);
		addr = next_rand() & 32'h0000_03ff;
		if (kind inside {MEM_LH, MEM_LHU, MEM_SH})
			addr[0] = 1'b0;
		if (kind inside {MEM_LW, MEM_SW})
			addr[1:0] = 2'b00;
		ins.op       = {2'b0, kind};
		ins.op_c.imm = next_rand() & 32'h0000_00fc;
		ins.op_a     = addr - ins.op_c.imm;
		exp_daddr    = {addr[31:2], 2'b00};
		exp_dwrite   = kind >= MEM_SB;
		exp_dwdata   = ins.op_b;
		exp_dwstb    = 4'b1111;
		if (kind == MEM_SB) begin
			exp_dwdata = {4{ins.op_b[7:0]}};
			exp_dwstb  = 4'b0001 << addr[1:0];
		end else if (kind == MEM_SH) begin
			exp_dwdata = {2{ins.op_b[15:0]}};
			exp_dwstb  = addr[1] ? 4'b1100 : 4'b0011;
		end
		// Loads pick the lane from the model word
		word = mem[addr[9:2]];
		case (kind)
			MEM_LB:  lval = {{24{word[addr[1:0]*8+7]}}, word[addr[1:0]*8 +: 8]};
			MEM_LBU: lval = {24'b0, word[addr[1:0]*8 +: 8]};
			MEM_LH:  lval = {{16{word[addr[1]*16+15]}}, word[addr[1]*16 +: 16]};
			MEM_LHU: lval = {16'b0, word[addr[1]*16 +: 16]};
			default: lval = word;
		endcase
		if (!exp_dwrite)
			expect_wb(ins.rd, lval);
		stall_left = next_rand() % 4;
		bus_seen   = 0;
		exp_pc     = seq_pc(ins.compressed);
		exp_seq    = 1'b1;
		run_instr(ins);
		if (!bus_seen) begin
			$display("load/store completed without a bus handshake");
			abort();
		end
	endtask

	task automatic do_mds();
		exec_instr_t ins;
		@(posedge clock);
		ins    = rand_instr(OP_MDS);
		ins.op = 6'(next_rand() % 10);
		if (next_rand() % 4 == 0)
			ins.op_b = 32'b0;
		expect_wb(ins.rd, mds_ref(ins.op[3:0], ins.op_a, ins.op_b));
		exp_pc  = seq_pc(ins.compressed);
		exp_seq = 1'b1;
		run_instr(ins);
	endtask

	task automatic do_csr();
		exec_instr_t ins;
		@(posedge clock);
		ins    = rand_instr(OP_CSR);
		ins.op = 6'(next_rand() % 5);
		ins.op_c.csr.idx = {1'b1, 5'(next_rand())};
		expect_wb(ins.op_c.csr.idx, alu_ref(ins.op[3:0], ins.op_a, ins.op_b));
		expect_wb(ins.rd, ins.op_b);
		exp_pc  = seq_pc(ins.compressed);
		exp_seq = 1'b1;
		run_instr(ins);
	endtask

	task automatic do_system(input sys_op_e op);
		exec_instr_t ins;
		@(posedge clock);
		ins    = rand_instr(OP_SYSTEM);
		ins.op = {4'b0, op};
		exp_seq = 1'b0;
		if (op == SYS_ERET) begin
			exp_pc = ins.op_a;
		end else begin
			expect_wb(CSR_MEPC, exp_pc);
			expect_wb(CSR_MTVAL, 32'b0);
			expect_wb(CSR_MCAUSE, (op == SYS_EBREAK) ? 32'd3 : 32'd11);
			exp_pc = MTVEC;
		end
		run_instr(ins);
	endtask

	// Memory model, grants after stall_left cycles
	always @(posedge clock) begin
		if (reset) begin
			dready <= 1'b0;
		end else begin
			dready <= 1'b0;
			if (dvalid && !dready) begin
				if (stall_left == 0) begin
					check("daddr", daddr, exp_daddr);
					check("dwrite", {31'b0, dwrite}, {31'b0, exp_dwrite});
					drdata <= mem[daddr[9:2]];
					if (dwrite) begin
						check("dwdata", dwdata, exp_dwdata);
						check("dwstb", {28'b0, dwstb}, {28'b0, exp_dwstb});
						for (int i = 0; i < 4; i++)
							if (dwstb[i])
								mem[daddr[9:2]][i*8 +: 8] = dwdata[i*8 +: 8];
					end
					dready <= 1'b1;
					bus_seen = 1;
				end else begin
					stall_left = stall_left - 1;
				end
			end
		end
	end

	// Write-back and completion monitor
	always @(negedge clock) begin
		exec_wb_t e;
		if (!reset) begin
			if (wb.en) begin
				if (exp_q.size() == 0) begin
					$display("register write with none expected");
					abort();
				end
				e = exp_q.pop_front();
				check("wb.addr", {26'b0, wb.addr}, {26'b0, e.addr});
				check("wb.data", wb.data, e.data);
			end
			if (instr_complete) begin
				check("pc", pc, exp_pc);
				check("pc_seq", {31'b0, pc_seq}, {31'b0, exp_seq});
				if (exp_q.size() != 0) begin
					$display("instruction completed with writes still missing");
					abort();
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		decode_valid = 1'b0;
		instr = '0;
		mtvec = MTVEC;
		dep_lo = 32'b0;
		dep_hi = 32'b0;
		drdata = 32'b0;
		dready = 1'b0;
		exp_pc = RESET_PC;
		exp_seq = 1'b1;
		stall_left = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = i * 32'h9e37_79b1 + 32'h0bad_c0de;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check("pc", pc, RESET_PC);
		check("pc_seq", {31'b0, pc_seq}, 32'd1);
		check("instr_complete", {31'b0, instr_complete}, 32'd0);
		check("wb.en", {31'b0, wb.en}, 32'd0);
		check("dvalid", {31'b0, dvalid}, 32'd0);
		repeat (200) do_arith();
		repeat (100) do_branch();
		repeat (40) do_jump();
		// Window enabled, roughly half of the targets fall outside
		@(posedge clock);
		decode_valid <= 1'b0;
		dep_lo <= 32'h1000_0001;
		dep_hi <= 32'h1fff_fff9;
		repeat (100) do_jump();
		repeat (150) do_ldst();
		repeat (150) do_mds();
		repeat (40) do_csr();
		repeat (5) begin
			do_system(SYS_ECALL);
			do_system(SYS_EBREAK);
			do_system(SYS_ERET);
		end
		@(posedge clock);
		decode_valid <= 1'b0;
		repeat (4) @(posedge clock);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: flist.f
src/exec_pkg.sv
src/exec_alu.sv
src/exec_mul_div_shift.sv
src/exec_mem.sv
src/exec_unit.sv
src/exec_top.sv
test/tb_exec.sv

// File: Makefile
# Verilator build of the execute stage testbench

OBJ = obj_dir

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exec \
		-f flist.f --Mdir $(OBJ) -o tb_exec
	./$(OBJ)/tb_exec

clean:
	rm -rf $(OBJ)

.PHONY: sim clean
